//--- Makefile
# Verilator build and run for the stream pacer testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := stream_pacer_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := ALL TESTS PASSED

SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
src/pacer_pkg.sv
src/step_counter.sv
src/pace_timer.sv
src/transfer_ctrl.sv
src/stream_pacer.sv
verification/stream_pacer_properties.sv
verification/stream_pacer_tb.sv

//--- src/pace_timer.sv
// Slot timer: counts cycles or synchronized trigger edges and opens the transfer slot
`timescale 1ns/1ns

module pace_timer
  import pacer_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  pace_cfg_t run_cfg,
  input  logic      busy,
  input  logic      clear,
  input  logic      trigger,
  output logic      slot_open
);

  logic      trig_meta;
  logic      trig_sync;
  logic      trig_last;
  logic      trig_rise;
  logic      step_src;
  logic      count_step;
  logic      count_hit;
  interval_t count_value;

  // ********************
  // Trigger synchronizer
  // ********************

  // Two flops into the clk domain, a third one keeps the last level
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trig_meta <= 1'b0;
      trig_sync <= 1'b0;
      trig_last <= 1'b0;
    end else begin
      trig_meta <= trigger;
      trig_sync <= trig_meta;
      trig_last <= trig_sync;
    end
  end

  assign trig_rise = trig_sync & ~trig_last;

  // ********************
  // Interval counting
  // ********************

  always_comb begin
    case (run_cfg.mode)
      PACE_FREE:    step_src = 1'b1;
      PACE_TRIGGER: step_src = trig_rise;
      default:      step_src = 1'b0;
    endcase
  end

  // Count freezes at the interval until the controller clears it
  assign count_hit  = (count_value == run_cfg.interval);
  assign count_step = busy & step_src & ~count_hit;

  step_counter #(
    .count_t(interval_t)
  ) i_interval_counter (
    .clk  (clk),
    .rst_n(rst_n),
    .clear(clear),
    .step (count_step),
    .value(count_value)
  );

  // Immediate mode never waits
  assign slot_open = (run_cfg.mode == PACE_IMMEDIATE) ? 1'b1 : count_hit;

endmodule

//--- src/pacer_pkg.sv
// Shared widths, pacing modes and the configuration and sink structs, imported by every module
package pacer_pkg;

  // ********************
  // Widths
  // ********************

  localparam int DATA_W     = 32;
  localparam int INTERVAL_W = 16;
  localparam int BEAT_W     = 8;

  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [INTERVAL_W-1:0] interval_t;
  typedef logic [BEAT_W-1:0]     beat_t;

  // ********************
  // Pacing modes
  // ********************

  // How a transfer slot opens
  typedef enum logic [1:0] {
    PACE_FREE      = 2'd0,
    PACE_TRIGGER   = 2'd1,
    PACE_IMMEDIATE = 2'd2
  } pace_mode_e;

  // ********************
  // Configuration and sink word
  // ********************

  // Captured on an accepted start, 28 bits
  typedef struct packed {
    // Cycles or trigger edges between slots
    interval_t  interval;
    // Transfers per run, zero stands for 256
    beat_t      beats;
    pace_mode_e mode;
    // Low selects sink A
    logic       sink_sel;
    logic       repeat_run;
  } pace_cfg_t;

  // Word presented to one sink, 33 bits
  typedef struct packed {
    logic  valid;
    data_t data;
  } sink_out_t;

endpackage

//--- src/step_counter.sv
// Clearable up counter for any payload type, used for the slot interval and the beat count
`timescale 1ns/1ns

module step_counter #(
  parameter type count_t = logic [7:0]
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   clear,
  input  logic   step,
  output count_t value
);

  count_t count_q;
  count_t count_next;

  // Clear has priority over step, the count wraps at its width
  always_comb begin
    count_next = count_q;
    if (clear) begin
      count_next = '0;
    end else if (step) begin
      count_next = count_q + count_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      count_q <= count_next;
    end
  end

  assign value = count_q;

endmodule

//--- src/stream_pacer.sv
// Stream pacer top level: moves source words to sink A or B at a paced rate for a set run length
`timescale 1ns/1ns

module stream_pacer
  import pacer_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  input  pace_cfg_t cfg,
  input  logic      abort,
  input  logic      trigger,
  input  logic      src_valid,
  input  data_t     src_data,
  output logic      src_ready,
  output sink_out_t sink_a,
  output sink_out_t sink_b,
  input  logic      sink_a_ready,
  input  logic      sink_b_ready,
  output logic      busy,
  output logic      done,
  output logic      stall
);

  pace_cfg_t run_cfg;
  logic      timer_clear;
  logic      slot_open;
  logic      beat_step;
  logic      beat_clear;
  beat_t     beat_value;

  // ********************
  // Slot timer
  // ********************

  pace_timer i_pace_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .run_cfg  (run_cfg),
    .busy     (busy),
    .clear    (timer_clear),
    .trigger  (trigger),
    .slot_open(slot_open)
  );

  // Beats moved in the current run
  step_counter #(
    .count_t(beat_t)
  ) i_beat_counter (
    .clk  (clk),
    .rst_n(rst_n),
    .clear(beat_clear),
    .step (beat_step),
    .value(beat_value)
  );

  // ********************
  // Controller
  // ********************

  transfer_ctrl i_transfer_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .cfg         (cfg),
    .abort       (abort),
    .slot_open   (slot_open),
    .beat_value  (beat_value),
    .src_valid   (src_valid),
    .src_data    (src_data),
    .sink_a_ready(sink_a_ready),
    .sink_b_ready(sink_b_ready),
    .run_cfg     (run_cfg),
    .busy        (busy),
    .timer_clear (timer_clear),
    .beat_step   (beat_step),
    .beat_clear  (beat_clear),
    .src_ready   (src_ready),
    .sink_a      (sink_a),
    .sink_b      (sink_b),
    .done        (done),
    .stall       (stall)
  );

endmodule

//--- src/transfer_ctrl.sv
// Transfer controller: run state, configuration capture, fire decision, sink routing and run end
`timescale 1ns/1ns

module transfer_ctrl
  import pacer_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  input  pace_cfg_t cfg,
  input  logic      abort,
  input  logic      slot_open,
  input  beat_t     beat_value,
  input  logic      src_valid,
  input  data_t     src_data,
  input  logic      sink_a_ready,
  input  logic      sink_b_ready,
  output pace_cfg_t run_cfg,
  output logic      busy,
  output logic      timer_clear,
  output logic      beat_step,
  output logic      beat_clear,
  output logic      src_ready,
  output sink_out_t sink_a,
  output sink_out_t sink_b,
  output logic      done,
  output logic      stall
);

  logic      busy_q;
  pace_cfg_t cfg_q;
  logic      start_ok;
  logic      sel_ready;
  logic      fire;
  logic      last_beat;

  // ********************
  // Run state
  // ********************

  // A start during a run is dropped
  assign start_ok = start & ~busy_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      cfg_q  <= '0;
    end else begin
      if (start_ok) begin
        cfg_q <= cfg;
      end
      if (abort) begin
        busy_q <= 1'b0;
      end else if (start_ok) begin
        busy_q <= 1'b1;
      end else if (done && !cfg_q.repeat_run) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign busy    = busy_q;
  assign run_cfg = cfg_q;

  // ********************
  // Fire and routing
  // ********************

  assign sel_ready = cfg_q.sink_sel ? sink_b_ready : sink_a_ready;
  assign fire      = busy_q & slot_open & src_valid & sel_ready;

  // Beats of zero wraps to 255, so the run is 256 long
  assign last_beat = (beat_value == beat_t'(cfg_q.beats - 1'b1));
  assign done      = fire & last_beat;

  assign src_ready = fire;

  // Both sinks see the word, only the selected one gets valid
  assign sink_a.valid = fire & ~cfg_q.sink_sel;
  assign sink_a.data  = src_data;
  assign sink_b.valid = fire & cfg_q.sink_sel;
  assign sink_b.data  = src_data;

  // Open slot held back by the source or the sink
  assign stall = busy_q & slot_open & ~(src_valid & sel_ready);

  // ********************
  // Counter control
  // ********************

  assign timer_clear = start_ok | fire | abort;
  assign beat_step   = fire;
  assign beat_clear  = start_ok | done | abort;

endmodule

//--- verification/stream_pacer_properties.sv
// Concurrent checks on the stream pacer outputs, bound into every stream_pacer instance
`timescale 1ns/1ns

module stream_pacer_properties
  import pacer_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input logic      abort,
  input logic      busy,
  input logic      done,
  input logic      src_ready,
  input sink_out_t sink_a,
  input sink_out_t sink_b
);

  // ********************
  // Routing
  // ********************

  // Only the selected sink sees a word
  a_one_sink: assert property (@(posedge clk) disable iff (!rst_n)
    !(sink_a.valid && sink_b.valid))
    else $error("Both sink valid bits are high in the same cycle");

  // The last beat is a real transfer
  a_done_fires: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> src_ready)
    else $error("Done is high without a transfer");

  // ********************
  // Run state
  // ********************

  a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> !(sink_a.valid || sink_b.valid))
    else $error("A sink valid bit is high while the pacer is idle");

  a_abort_stops: assert property (@(posedge clk) disable iff (!rst_n)
    abort |=> !busy)
    else $error("Busy is still high in the cycle after an abort");

endmodule

bind stream_pacer stream_pacer_properties i_properties (
  .clk      (clk),
  .rst_n    (rst_n),
  .abort    (abort),
  .busy     (busy),
  .done     (done),
  .src_ready(src_ready),
  .sink_a   (sink_a),
  .sink_b   (sink_b)
);

//--- verification/stream_pacer_tb.sv
// Directed testbench for the stream pacer, run as the simulation top with the properties bound in
`timescale 1ns/1ns

module stream_pacer_tb
  import pacer_pkg::*;
();

  logic      clk = 1'b0;
  logic      rst_n;
  logic      start;
  pace_cfg_t cfg;
  logic      abort;
  logic      trigger;
  logic      src_valid;
  data_t     src_data = '0;
  logic      sink_a_ready = 1'b0;
  logic      sink_b_ready = 1'b0;
  logic      src_ready;
  sink_out_t sink_a;
  sink_out_t sink_b;
  logic      busy;
  logic      done;
  logic      stall;

  // Edge count, sink records and per-run snapshots
  int    cyc = 0;
  logic  src_take = 1'b0;
  logic  bp_en = 1'b0;
  logic  a_ready_level = 1'b0;
  logic  b_ready_level = 1'b0;
  logic  stall_check_b = 1'b0;
  string test_name = "reset";
  int    start_edge;
  int    fire_base;
  int    done_base;
  int    a_base;
  int    b_base;
  data_t word_base;
  int    fire_edges[$];
  int    done_edges[$];
  data_t a_words[$];
  data_t b_words[$];

  stream_pacer i_dut (
    .clk(clk), .rst_n(rst_n), .start(start), .cfg(cfg), .abort(abort), .trigger(trigger),
    .src_valid(src_valid), .src_data(src_data), .src_ready(src_ready),
    .sink_a(sink_a), .sink_b(sink_b), .sink_a_ready(sink_a_ready),
    .sink_b_ready(sink_b_ready), .busy(busy), .done(done), .stall(stall)
  );

  always #20 clk = ~clk;

  // ********************
  // Source and sink models
  // ********************

  // Source steps to the next word after each accepted one
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (src_take) begin
      src_data <= src_data + 32'd1;
    end
    if (bp_en) begin
      sink_a_ready <= 1'($urandom);
      sink_b_ready <= 1'($urandom);
    end else begin
      sink_a_ready <= a_ready_level;
      sink_b_ready <= b_ready_level;
    end
  end

  // Sampled mid-cycle, entries hold the edge that takes the word
  always @(negedge clk) begin
    src_take = src_ready;
    if (src_ready) fire_edges.push_back(cyc + 1);
    if (done) done_edges.push_back(cyc + 1);
    if (sink_a.valid) a_words.push_back(sink_a.data);
    if (sink_b.valid) b_words.push_back(sink_b.data);
    if (stall_check_b && busy && src_valid) begin
      check_value("stall level", 32'(!sink_b_ready), 32'(stall));
    end
  end

  // ********************
  // Helpers
  // ********************

  task automatic fail_run(string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("ERR %s %s: expected %0h, actual %0h", test_name, what,
                         expected, actual));
    end
  endtask

  function automatic pace_cfg_t make_cfg(int interval, int beats, pace_mode_e mode,
                                         logic sel, logic rep);
    pace_cfg_t c;
    c.interval   = interval_t'(interval);
    c.beats      = beat_t'(beats);
    c.mode       = mode;
    c.sink_sel   = sel;
    c.repeat_run = rep;
    return c;
  endfunction

  task automatic hold_reset();
    rst_n <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic start_run(pace_cfg_t c);
    @(negedge clk);
    fire_base = fire_edges.size();
    done_base = done_edges.size();
    a_base    = a_words.size();
    b_base    = b_words.size();
    word_base = src_data;
    @(posedge clk);
    start <= 1'b1;
    cfg   <= c;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    start_edge = cyc;
    check_value("busy after start", 32'd1, 32'(busy));
  endtask

  task automatic wait_idle(int limit);
    int n;
    n = 0;
    while (busy && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (busy) fail_run({"Timeout: busy did not fall in test ", test_name});
  endtask

  task automatic wait_fires(int count, int limit);
    int n;
    n = 0;
    while (fire_edges.size() - fire_base < count && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (fire_edges.size() - fire_base < count) begin
      fail_run({"Timeout: too few transfers seen in test ", test_name});
    end
  endtask

  // Transfers and sink words of the current run stay at the given count
  task automatic expect_no_fire(int fires, int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_value("transfers in window", 32'(fires), 32'(fire_edges.size() - fire_base));
      check_value("sink words in window", 32'(fires),
                  32'(a_words.size() - a_base + b_words.size() - b_base));
    end
  endtask

  task automatic pulse_trigger();
    @(posedge clk);
    trigger <= 1'b1;
    repeat (4) @(posedge clk);
    trigger <= 1'b0;
    repeat (4) @(posedge clk);
  endtask

  // Words on the selected sink follow the source sequence, none on the other
  task automatic check_sink_words(logic use_b, int count, int dones);
    int i;
    check_value("words on sink A", use_b ? 0 : count, 32'(a_words.size() - a_base));
    check_value("words on sink B", use_b ? count : 0, 32'(b_words.size() - b_base));
    for (i = 0; i < count; i++) begin
      check_value("word order", word_base + 32'(i),
                  use_b ? b_words[b_base + i] : a_words[a_base + i]);
    end
    check_value("done pulses", 32'(dones), 32'(done_edges.size() - done_base));
  endtask

  // ********************
  // Tests
  // ********************

  task automatic free_to_sink_a();
    int i;
    test_name     = "free_to_sink_a";
    a_ready_level = 1'b1;
    b_ready_level = 1'b1;
    @(posedge clk);
    src_valid <= 1'b1;
    start_run(make_cfg(3, 4, PACE_FREE, 1'b0, 1'b0));
    wait_idle(100);
    check_value("transfers", 32'd4, 32'(fire_edges.size() - fire_base));
    // One edge beyond the interval per slot
    for (i = 0; i < 4; i++) begin
      check_value("transfer edge", 32'(start_edge + (i + 1) * 4), 32'(fire_edges[fire_base + i]));
    end
    check_sink_words(1'b0, 4, 1);
    check_value("done with last word", 32'(fire_edges[fire_base + 3]), 32'(done_edges[done_base]));
    check_value("busy falls after done", 32'(done_edges[done_base]), 32'(cyc));
  endtask

  task automatic immediate_backpressure_b();
    test_name     = "immediate_backpressure_b";
    bp_en         = 1'b1;
    stall_check_b = 1'b1;
    start_run(make_cfg(0, 10, PACE_IMMEDIATE, 1'b1, 1'b0));
    wait_idle(400);
    bp_en         = 1'b0;
    stall_check_b = 1'b0;
    check_sink_words(1'b1, 10, 1);
  endtask

  task automatic trigger_paced();
    int k;
    test_name = "trigger_paced";
    start_run(make_cfg(2, 3, PACE_TRIGGER, 1'b0, 1'b0));
    for (k = 1; k <= 3; k++) begin
      pulse_trigger();
      expect_no_fire(k - 1, 12);
      pulse_trigger();
      wait_fires(k, 20);
    end
    wait_idle(20);
    check_sink_words(1'b0, 3, 1);
  endtask

  task automatic repeat_then_abort();
    int nf;
    int k;
    test_name = "repeat_then_abort";
    start_run(make_cfg(0, 2, PACE_IMMEDIATE, 1'b0, 1'b1));
    wait_fires(6, 40);
    check_value("busy during repeat", 32'd1, 32'(busy));
    @(posedge clk);
    abort <= 1'b1;
    @(posedge clk);
    abort <= 1'b0;
    @(negedge clk);
    check_value("busy after abort", 32'd0, 32'(busy));
    nf = fire_edges.size() - fire_base;
    expect_no_fire(nf, 20);
    // Every second transfer closes a run
    check_value("done pulses", 32'(nf / 2), 32'(done_edges.size() - done_base));
    for (k = 0; k < nf / 2; k++) begin
      check_value("done edge", 32'(fire_edges[fire_base + 2 * k + 1]),
                  32'(done_edges[done_base + k]));
    end
  endtask

  task automatic start_while_busy();
    test_name     = "start_while_busy";
    // Reset lands on a run whose open slot is held by sink A
    a_ready_level = 1'b0;
    start_run(make_cfg(0, 8, PACE_IMMEDIATE, 1'b0, 1'b0));
    check_value("stall before reset", 32'd1, 32'(stall));
    @(posedge clk);
    hold_reset();
    @(negedge clk);
    check_value("busy after reset", 32'd0, 32'(busy));
    check_value("done after reset", 32'd0, 32'(done));
    check_value("stall after reset", 32'd0, 32'(stall));
    a_ready_level = 1'b1;
    start_run(make_cfg(3, 3, PACE_FREE, 1'b0, 1'b0));
    repeat (2) @(posedge clk);
    start <= 1'b1;
    cfg   <= make_cfg(1, 8, PACE_FREE, 1'b1, 1'b0);
    @(posedge clk);
    start <= 1'b0;
    wait_idle(100);
    check_sink_words(1'b0, 3, 1);
  endtask

  initial begin
    void'($urandom(32'h517a_a1d1));
    rst_n     = 1'b0;
    start     = 1'b0;
    cfg       = '0;
    abort     = 1'b0;
    trigger   = 1'b0;
    src_valid = 1'b0;
    hold_reset();
    free_to_sink_a();
    immediate_backpressure_b();
    trigger_paced();
    repeat_then_abort();
    start_while_busy();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
